// ==== logic/npc_pkg.sv ====
package npc_pkg;

    localparam int XLEN = 32;

    // machine word, also used for pc, immediates and addresses
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     inst_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    // one bit per byte lane
    typedef logic [3:0]      wmask_t;

    localparam xlen_t RESET_PC  = 32'h8000_0000;

    // data memory window
    localparam xlen_t DMEM_BASE  = 32'h8000_1000;
    localparam int    DMEM_WORDS = 256;
    localparam int    DMEM_IDX_W = $clog2(DMEM_WORDS);
    localparam xlen_t DMEM_BYTES = DMEM_WORDS * 4;

    typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;

    // rv32i major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // funct3 values of the supported subset
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_JALR = 3'b000;
    localparam funct3_t F3_LW   = 3'b010;
    localparam funct3_t F3_LBU  = 3'b100;
    localparam funct3_t F3_SB   = 3'b000;
    localparam funct3_t F3_SW   = 3'b010;

    localparam inst_t INST_EBREAK = 32'h0010_0073;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK,
        WB_IMM
    } wb_sel_e;

    typedef enum logic [1:0] {
        NPC_SEQ,
        NPC_JAL,
        NPC_JALR
    } next_pc_e;

    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        logic     reg_wen;
        logic     mem_ren;
        logic     mem_wen;
        logic     byte_access;
        logic     src1_is_pc;
        logic     src2_is_imm;
        wb_sel_e  wb_sel;
        next_pc_e next_pc;
        logic     is_ebreak;
        logic     illegal;
    } ctrl_t;

    // one retired instruction, rd_wen is low for writes to x0
    typedef struct packed {
        xlen_t    pc;
        logic     rd_wen;
        reg_idx_t rd;
        xlen_t    rd_data;
        logic     store;
    } retire_t;

endpackage

// ==== logic/inst_decode.sv ====
module inst_decode
    import npc_pkg::*;
(
    input  inst_t inst,
    output ctrl_t ctrl
);

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_u;
    xlen_t imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // all immediates sign-extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl         = '0;
        ctrl.rd      = inst[11:7];
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.imm     = imm_i;
        ctrl.wb_sel  = WB_ALU;
        ctrl.next_pc = NPC_SEQ;

        case (opcode)
            OP_LUI: begin
                ctrl.imm     = imm_u;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_IMM;
            end
            OP_AUIPC: begin
                ctrl.imm         = imm_u;
                ctrl.reg_wen     = 1'b1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
            end
            OP_JAL: begin
                ctrl.imm     = imm_j;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = WB_LINK;
                ctrl.next_pc = NPC_JAL;
            end
            OP_JALR: begin
                if (funct3 == F3_JALR) begin
                    // target comes out of the adder as rs1 + imm
                    ctrl.reg_wen     = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.wb_sel      = WB_LINK;
                    ctrl.next_pc     = NPC_JALR;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    ctrl.reg_wen     = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_REG: begin
                // sub and the other R-type ops are not implemented
                if (funct3 == F3_ADD && funct7 == 7'b0) begin
                    ctrl.reg_wen = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_LOAD: begin
                if (funct3 == F3_LW || funct3 == F3_LBU) begin
                    ctrl.reg_wen     = 1'b1;
                    ctrl.mem_ren     = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.byte_access = (funct3 == F3_LBU);
                    ctrl.wb_sel      = WB_MEM;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_STORE: begin
                ctrl.imm = imm_s;
                if (funct3 == F3_SW || funct3 == F3_SB) begin
                    ctrl.mem_wen     = 1'b1;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.byte_access = (funct3 == F3_SB);
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OP_SYSTEM: begin
                // only ebreak, ecall and csr ops fall into illegal
                if (inst == INST_EBREAK) begin
                    ctrl.is_ebreak = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== logic/register_file.sv ====
module register_file
    import npc_pkg::*;
(
    input  logic     clk,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    // x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, old value when the same register is written this cycle
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

// ==== logic/data_mem.sv ====
module data_mem
    import npc_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  xlen_t addr,
    input  logic  ren,
    input  logic  wen,
    input  logic  byte_access,
    input  xlen_t wdata,
    output xlen_t rdata
);

    xlen_t                 mem [DMEM_WORDS];
    logic [DMEM_WORDS-1:0] valid;

    xlen_t      offset;
    dmem_idx_t  idx;
    logic [1:0] lane;
    xlen_t      cur_word;
    logic [7:0] cur_byte;
    wmask_t     wmask;
    xlen_t      lane_data;
    xlen_t      merged;

    assign offset = addr - DMEM_BASE;
    assign idx    = offset[DMEM_IDX_W+1:2];
    assign lane   = offset[1:0];

    // words never written read as zero
    assign cur_word = valid[idx] ? mem[idx] : '0;
    assign cur_byte = cur_word[{lane, 3'b000} +: 8];

    assign rdata = !ren ? '0 : (byte_access ? {24'b0, cur_byte} : cur_word);

    assign wmask     = byte_access ? wmask_t'(4'b0001 << lane) : 4'b1111;
    assign lane_data = byte_access ? {4{wdata[7:0]}} : wdata;

    // unmasked lanes keep the current (possibly zeroed) contents
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = wmask[i] ? lane_data[8*i +: 8] : cur_word[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[idx] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (wen) begin
            valid[idx] <= 1'b1;
        end
    end

    a_in_range: assert property (@(posedge clk) disable iff (reset)
        (ren || wen) |-> offset < DMEM_BYTES);

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        ((ren || wen) && !byte_access) |-> lane == 2'b00);

endmodule

// ==== logic/npc.sv ====
module npc
    import npc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output xlen_t   imem_addr,
    input  inst_t   imem_data,
    output retire_t retire,
    output logic    retire_valid,
    output logic    halted
);

    xlen_t pc;
    xlen_t next_pc;
    xlen_t pc_plus4;
    xlen_t pc_plus_imm;

    ctrl_t ctrl;

    xlen_t src1;
    xlen_t src2;
    xlen_t alu_src1;
    xlen_t alu_src2;
    xlen_t alu_result;
    xlen_t mem_rdata;
    xlen_t wb_data;

    logic run;
    logic rf_wen;
    logic dm_ren;
    logic dm_wen;

    assign imem_addr = pc;

    inst_decode u_inst_decode (
        .inst (imem_data),
        .ctrl (ctrl)
    );

    // the core executes one instruction per cycle unless stopped
    assign run    = !reset && !halted;
    assign rf_wen = run && ctrl.reg_wen;
    assign dm_ren = run && ctrl.mem_ren;
    assign dm_wen = run && ctrl.mem_wen;

    register_file u_register_file (
        .clk    (clk),
        .wen    (rf_wen),
        .waddr  (ctrl.rd),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    // add-only alu, also gives load/store and jalr addresses
    assign alu_src1   = ctrl.src1_is_pc ? pc : src1;
    assign alu_src2   = ctrl.src2_is_imm ? ctrl.imm : src2;
    assign alu_result = alu_src1 + alu_src2;

    data_mem u_data_mem (
        .clk         (clk),
        .reset       (reset),
        .addr        (alu_result),
        .ren         (dm_ren),
        .wen         (dm_wen),
        .byte_access (ctrl.byte_access),
        .wdata       (src2),
        .rdata       (mem_rdata)
    );

    assign pc_plus4    = pc + 32'd4;
    assign pc_plus_imm = pc + ctrl.imm;

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_rdata;
            WB_LINK: wb_data = pc_plus4;
            WB_IMM:  wb_data = ctrl.imm;
            default: wb_data = alu_result;
        endcase
    end

    always_comb begin
        case (ctrl.next_pc)
            NPC_JAL:  next_pc = pc_plus_imm;
            NPC_JALR: next_pc = {alu_result[31:1], 1'b0};
            default:  next_pc = pc_plus4;
        endcase
    end

    // pc holds once halted
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (run) begin
            pc <= next_pc;
        end
    end

    // ebreak or an unknown encoding stops the core until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (run && (ctrl.is_ebreak || ctrl.illegal)) begin
            halted <= 1'b1;
        end
    end

    assign retire_valid    = run;
    assign retire.pc       = pc;
    assign retire.rd_wen   = rf_wen && ctrl.rd != '0;
    assign retire.rd       = ctrl.rd;
    assign retire.rd_data  = wb_data;
    assign retire.store    = dm_wen;

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// ==== testbench/npc_tb.sv ====
module npc_tb
    import npc_pkg::*;
();

    localparam int PROG_LEN   = 200;
    localparam int MAX_CYCLES = PROG_LEN * 2 + 20;

    // x31 holds the data memory base, x30 the jalr target
    localparam reg_idx_t BASE_REG = 5'd31;
    localparam reg_idx_t LINK_REG = 5'd30;

    logic    clk;
    logic    reset;
    xlen_t   imem_addr;
    inst_t   imem_data;
    retire_t retire;
    logic    retire_valid;
    logic    halted;

    inst_t      prog [0:PROG_LEN];
    xlen_t      model_regs [32];
    logic [7:0] model_mem [DMEM_WORDS * 4];
    xlen_t      model_pc;
    logic       model_done;
    logic       stop;

    int seed;
    int checks;
    int mismatches;
    int failures;
    int cycles;
    int dut_retired;
    int model_retired;

    npc dut (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    always #20 clk = ~clk;

    // retirements seen at the DUT, counted apart from the model
    always @(posedge clk) begin
        if (retire_valid) begin
            dut_retired <= dut_retired + 1;
        end
    end

    // anything outside the program reads as an illegal all-zero word
    function automatic inst_t fetch_inst(input xlen_t addr);
        xlen_t off;
        off = addr - RESET_PC;
        if (off[1:0] != 2'b00 || off > xlen_t'(PROG_LEN * 4)) begin
            return '0;
        end
        return prog[off[9:2]];
    endfunction

    assign imem_data = fetch_inst(imem_addr);

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // sign extension from an arbitrary bit width
    function automatic xlen_t sext(input xlen_t v, input int bits);
        return $unsigned($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    function automatic inst_t i_type(input opcode_t op, input funct3_t f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t r_type(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        return {7'b0, rs2, rs1, F3_ADD, rd, OP_REG};
    endfunction

    function automatic inst_t s_type(input funct3_t f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t u_type(input opcode_t op, input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic inst_t j_type(input reg_idx_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // memory ops use x31 as base and stay in the first 128 bytes
    function automatic inst_t random_simple();
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        rd  = reg_idx_t'(rand_below(30));
        rs1 = reg_idx_t'(rand_below(32));
        rs2 = reg_idx_t'(rand_below(32));
        case (rand_below(8))
            0: return i_type(OP_IMM, F3_ADD, rd, rs1, 12'(rand_below(4096)));
            1: return r_type(rd, rs1, rs2);
            2: return u_type(OP_LUI, rd, 20'(rand_below(1 << 20)));
            3: return u_type(OP_AUIPC, rd, 20'(rand_below(1 << 20)));
            4: return i_type(OP_LOAD, F3_LW, rd, BASE_REG, 12'(rand_below(32) * 4));
            5: return i_type(OP_LOAD, F3_LBU, rd, BASE_REG, 12'(rand_below(128)));
            6: return s_type(F3_SW, BASE_REG, rs2, 12'(rand_below(32) * 4));
            default: return s_type(F3_SB, BASE_REG, rs2, 12'(rand_below(128)));
        endcase
    endfunction

    task automatic place_inst(input int slot, input inst_t w);
        prog[8'(slot)] = w;
    endtask

    task automatic gen_program();
        int       i;
        int       kind;
        int       skip;
        reg_idx_t rd;
        xlen_t    taddr;
        place_inst(0, u_type(OP_LUI, BASE_REG, DMEM_BASE[31:12]));
        i = 1;
        while (i < PROG_LEN) begin
            kind = rand_below(16);
            skip = 1 + rand_below(2);
            rd   = reg_idx_t'(rand_below(30));
            if (kind == 0 && i + 1 + skip <= PROG_LEN) begin
                place_inst(i, j_type(rd, 21'((skip + 1) * 4)));
                i = i + 1;
            end else if (kind == 1 && i + 3 + skip <= PROG_LEN) begin
                // load the target into x30, sometimes with bit 0 set in the offset
                taddr = RESET_PC + xlen_t'((i + 3 + skip) * 4);
                place_inst(i, u_type(OP_LUI, LINK_REG, 20'((taddr + 32'h800) >> 12)));
                place_inst(i + 1, i_type(OP_IMM, F3_ADD, LINK_REG, LINK_REG, taddr[11:0]));
                place_inst(i + 2, i_type(OP_JALR, F3_JALR, rd, LINK_REG, 12'(rand_below(2))));
                i = i + 3;
            end else begin
                skip = 0;
                place_inst(i, random_simple());
                i = i + 1;
            end
            // skipped slots only get single instructions
            repeat (skip) begin
                place_inst(i, random_simple());
                i = i + 1;
            end
        end
        place_inst(PROG_LEN, INST_EBREAK);
    endtask

    task automatic write_reg(inout retire_t exp, input reg_idx_t rd, input xlen_t v);
        if (rd != '0) begin
            model_regs[rd] = v;
            exp.rd_wen     = 1'b1;
            exp.rd         = rd;
            exp.rd_data    = v;
        end
    endtask

    // ISA-level step of the reference model
    task automatic model_step(output retire_t exp);
        inst_t      w;
        reg_idx_t   rd;
        xlen_t      a;
        xlen_t      b;
        xlen_t      npc;
        xlen_t      upper;
        logic [9:0] boff;
        w     = fetch_inst(model_pc);
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        upper = {w[31:12], 12'b0};
        exp    = '0;
        exp.pc = model_pc;
        npc    = model_pc + 32'd4;
        case (w[6:0])
            OP_LUI:   write_reg(exp, rd, upper);
            OP_AUIPC: write_reg(exp, rd, model_pc + upper);
            OP_JAL: begin
                npc = model_pc + sext({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                write_reg(exp, rd, model_pc + 32'd4);
            end
            OP_JALR: begin
                npc = (a + sext({20'b0, w[31:20]}, 12)) & ~32'd1;
                write_reg(exp, rd, model_pc + 32'd4);
            end
            OP_IMM: write_reg(exp, rd, a + sext({20'b0, w[31:20]}, 12));
            OP_REG: write_reg(exp, rd, a + b);
            OP_LOAD: begin
                boff = 10'(a + sext({20'b0, w[31:20]}, 12) - DMEM_BASE);
                if (w[14:12] == F3_LBU) begin
                    write_reg(exp, rd, {24'b0, model_mem[boff]});
                end else begin
                    write_reg(exp, rd, {model_mem[boff + 10'd3], model_mem[boff + 10'd2],
                                        model_mem[boff + 10'd1], model_mem[boff]});
                end
            end
            OP_STORE: begin
                exp.store = 1'b1;
                boff = 10'(a + sext({20'b0, w[31:25], w[11:7]}, 12) - DMEM_BASE);
                model_mem[boff] = b[7:0];
                if (w[14:12] == F3_SW) begin
                    model_mem[boff + 10'd1] = b[15:8];
                    model_mem[boff + 10'd2] = b[23:16];
                    model_mem[boff + 10'd3] = b[31:24];
                end
            end
            default: model_done = 1'b1;
        endcase
        model_pc      = npc;
        model_retired = model_retired + 1;
    endtask

    task automatic compare_value(input string name, input xlen_t got, input xlen_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            mismatches = mismatches + 1;
            $display("MISMATCH %s got %h expected %h in cycle %0d", name, got, exp, cycles);
        end
    endtask

    task automatic check_retire();
        retire_t exp;
        model_step(exp);
        compare_value("retire.pc", retire.pc, exp.pc);
        compare_value("retire.rd_wen", xlen_t'(retire.rd_wen), xlen_t'(exp.rd_wen));
        compare_value("retire.store", xlen_t'(retire.store), xlen_t'(exp.store));
        if (exp.rd_wen) begin
            compare_value("retire.rd", xlen_t'(retire.rd), xlen_t'(exp.rd));
            compare_value("retire.rd_data", retire.rd_data, exp.rd_data);
        end
    endtask

    // core must stay stopped with pc held at the model's next pc
    task automatic check_halt();
        repeat (5) begin
            @(negedge clk);
            cycles = cycles + 1;
            compare_value("halted", xlen_t'(halted), 32'd1);
            compare_value("retire_valid", xlen_t'(retire_valid), 32'd0);
            compare_value("imem_addr", imem_addr, model_pc);
        end
        compare_value("retired count", xlen_t'(dut_retired), xlen_t'(model_retired));
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        seed          = 32'heaa7_230d;
        checks        = 0;
        mismatches    = 0;
        failures      = 0;
        cycles        = 0;
        dut_retired   = 0;
        model_retired = 0;
        model_done    = 1'b0;
        stop          = 1'b0;
        model_pc      = RESET_PC;
        model_regs    = '{default: '0};
        model_mem     = '{default: 8'h00};
        gen_program();

        @(posedge clk);
        @(negedge clk);
        compare_value("retire_valid", xlen_t'(retire_valid), 32'd0);
        compare_value("halted", xlen_t'(halted), 32'd0);
        @(posedge clk);
        reset <= 1'b0;

        while (!model_done && !stop) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: ebreak not reached within %0d cycles", MAX_CYCLES);
                failures = failures + 1;
                stop     = 1'b1;
            end else if (!retire_valid) begin
                $display("core stopped retiring at pc %h before the model reached ebreak",
                         imem_addr);
                failures = failures + 1;
                stop     = 1'b1;
            end else begin
                check_retire();
            end
        end
        if (model_done) begin
            check_halt();
        end

        $display("checks %0d, mismatches %0d, other failures %0d, retired %0d",
                 checks, mismatches, failures, dut_retired);
        if (mismatches == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/npc_pkg.sv
logic/inst_decode.sv
logic/register_file.sv
logic/data_mem.sv
logic/npc.sv
testbench/npc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the npc testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module npc_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vnpc_tb)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
